/* hdl/dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// byte address seen by the core and by memory
`define DCACHE_ADDR_W    32

// one 64-bit word per line
`define DCACHE_WORD_W    64
`define DCACHE_MASK_W    8

// address split, offset picks the byte inside the word
`define DCACHE_OFFSET_W  3
`define DCACHE_INDEX_W   6
`define DCACHE_SETS      64

// whatever is left above index and offset
`define DCACHE_TAG_W     (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

`endif

/* hdl/dcache_pkg.sv */
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    // byte address as the cache sees it
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]    tag;
        logic [`DCACHE_INDEX_W-1:0]  index;
        logic [`DCACHE_OFFSET_W-1:0] offset;
    } dcache_addr_t;

    // held by the core until done
    typedef struct packed {
        logic                      write;
        dcache_addr_t              addr;
        logic [`DCACHE_WORD_W-1:0] wdata;
        logic [`DCACHE_MASK_W-1:0] mask;
    } core_req_t;

    typedef struct packed {
        logic                      done;
        logic [`DCACHE_WORD_W-1:0] rdata;
    } core_rsp_t;

    // addr is always word aligned
    typedef struct packed {
        logic                      valid;
        logic                      write;
        logic [`DCACHE_ADDR_W-1:0] addr;
        logic [`DCACHE_WORD_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                      ack;
        logic [`DCACHE_WORD_W-1:0] rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WBACK,
        REFILL,
        DONE
    } ctrl_state_t;

    typedef logic way_t;

endpackage

`default_nettype wire

/* hdl/dcache_core_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_config.svh"

module dcache_core_port (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid_i,
    input  dcache_pkg::core_req_t     core_req_i,
    input  logic                      finish_i,
    input  logic [`DCACHE_WORD_W-1:0] rdata_i,
    output dcache_pkg::core_rsp_t     core_rsp_o,
    output dcache_pkg::core_req_t     req_o,
    output logic                      req_pending_o
);

    logic                      pending_q;
    logic                      done_q;
    logic [`DCACHE_WORD_W-1:0] rdata_q;
    logic                      capture;

    // the core still holds the old request during the done cycle
    assign capture = req_valid_i && !pending_q && !done_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            if (capture) begin
                pending_q <= 1'b1;
            end else if (finish_i) begin
                pending_q <= 1'b0;
            end
            done_q <= finish_i;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            req_o <= core_req_i;
        end
        if (finish_i) begin
            rdata_q <= rdata_i;
        end
    end

    assign req_pending_o = pending_q;
    assign core_rsp_o    = '{done: done_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* hdl/dcache_tag_store.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_config.svh"

module dcache_tag_store (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_pkg::dcache_addr_t addr_i,
    input  logic                     upd_i,
    input  dcache_pkg::way_t         upd_way_i,
    input  logic                     upd_valid_i,
    input  logic                     upd_dirty_i,
    input  logic                     touch_i,
    output logic                     hit_o,
    output dcache_pkg::way_t         hit_way_o,
    output dcache_pkg::way_t         victim_way_o,
    output logic                     victim_dirty_o,
    output dcache_pkg::dcache_addr_t victim_addr_o
);
    import dcache_pkg::*;

    logic [`DCACHE_TAG_W-1:0] tag_q [2][`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0]  valid_q [2];
    logic [`DCACHE_SETS-1:0]  dirty_q [2];
    // lru_q holds the least recently used way of each set
    logic [`DCACHE_SETS-1:0]  lru_q;
    logic [1:0]               match;
    way_t                     victim;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = valid_q[w][addr_i.index] &&
                       (tag_q[w][addr_i.index] == addr_i.tag);
        end
    end

    assign hit_o     = |match;
    assign hit_way_o = match[1];

    // free way first, else the older one
    always_comb begin
        if (!valid_q[0][addr_i.index]) begin
            victim = 1'b0;
        end else if (!valid_q[1][addr_i.index]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[addr_i.index];
        end
    end

    assign victim_way_o   = victim;
    assign victim_dirty_o = valid_q[victim][addr_i.index] && dirty_q[victim][addr_i.index];
    assign victim_addr_o  = '{tag: tag_q[victim][addr_i.index],
                              index: addr_i.index,
                              offset: '0};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                tag_q[0][s] <= '0;
                tag_q[1][s] <= '0;
            end
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            lru_q      <= '0;
        end else begin
            if (upd_i) begin
                tag_q[upd_way_i][addr_i.index]   <= addr_i.tag;
                valid_q[upd_way_i][addr_i.index] <= upd_valid_i;
                dirty_q[upd_way_i][addr_i.index] <= upd_dirty_i;
            end
            // named way becomes most recent, so the other one is next out
            if (upd_i || touch_i) begin
                lru_q[addr_i.index] <= ~upd_way_i;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_data_store.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_config.svh"

module dcache_data_store (
    input  logic                       clk,
    input  logic [`DCACHE_INDEX_W-1:0] index_i,
    input  logic                       we_i,
    input  dcache_pkg::way_t           way_i,
    input  logic [`DCACHE_WORD_W-1:0]  wdata_i,
    input  logic [`DCACHE_MASK_W-1:0]  mask_i,
    output logic [`DCACHE_WORD_W-1:0]  rdata0_o,
    output logic [`DCACHE_WORD_W-1:0]  rdata1_o
);

    logic [`DCACHE_WORD_W-1:0] mem_q [2][`DCACHE_SETS];

    // byte merge, unmasked bytes keep their old value
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < `DCACHE_MASK_W; b++) begin
                if (mask_i[b]) begin
                    mem_q[way_i][index_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // both ways read at once, ctrl picks
    assign rdata0_o = mem_q[0][index_i];
    assign rdata1_o = mem_q[1][index_i];

endmodule

`default_nettype wire

/* hdl/dcache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  dcache_pkg::core_req_t     req_i,
    input  logic                      req_pending_i,
    input  logic                      hit_i,
    input  dcache_pkg::way_t          hit_way_i,
    input  dcache_pkg::way_t          victim_way_i,
    input  logic                      victim_dirty_i,
    input  logic [`DCACHE_WORD_W-1:0] rdata0_i,
    input  logic [`DCACHE_WORD_W-1:0] rdata1_i,
    input  logic                      mem_done_i,
    input  logic [`DCACHE_WORD_W-1:0] fill_data_i,
    output logic                      tag_upd_o,
    output dcache_pkg::way_t          tag_way_o,
    output logic                      tag_valid_o,
    output logic                      tag_dirty_o,
    output logic                      tag_touch_o,
    output logic                      data_we_o,
    output dcache_pkg::way_t          data_way_o,
    output logic [`DCACHE_WORD_W-1:0] data_wdata_o,
    output logic [`DCACHE_MASK_W-1:0] data_mask_o,
    output logic                      wb_start_o,
    output logic                      fill_start_o,
    output logic                      finish_o,
    output logic [`DCACHE_WORD_W-1:0] rdata_o
);
    import dcache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    way_t        sel_way;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // read word on a hit, victim word for the writeback on a miss
    assign sel_way = hit_i ? hit_way_i : victim_way_i;
    assign rdata_o = sel_way ? rdata1_i : rdata0_i;

    always_comb begin
        state_d      = state_q;
        tag_upd_o    = 1'b0;
        tag_way_o    = hit_way_i;
        tag_valid_o  = 1'b0;
        tag_dirty_o  = 1'b0;
        tag_touch_o  = 1'b0;
        data_we_o    = 1'b0;
        data_way_o   = hit_way_i;
        data_wdata_o = req_i.wdata;
        data_mask_o  = req_i.mask;
        wb_start_o   = 1'b0;
        fill_start_o = 1'b0;
        finish_o     = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_pending_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    finish_o    = 1'b1;
                    tag_touch_o = 1'b1;
                    if (req_i.write) begin
                        data_we_o   = 1'b1;
                        tag_upd_o   = 1'b1;
                        tag_valid_o = 1'b1;
                        tag_dirty_o = 1'b1;
                    end
                    state_d = DONE;
                end else if (victim_dirty_i) begin
                    wb_start_o = 1'b1;
                    state_d    = WBACK;
                end else begin
                    fill_start_o = 1'b1;
                    state_d      = REFILL;
                end
            end
            WBACK: begin
                if (mem_done_i) begin
                    fill_start_o = 1'b1;
                    state_d      = REFILL;
                end
            end
            REFILL: begin
                // whole word in, clean; LOOKUP then finishes as a hit
                if (mem_done_i) begin
                    data_we_o    = 1'b1;
                    data_way_o   = victim_way_i;
                    data_wdata_o = fill_data_i;
                    data_mask_o  = '1;
                    tag_upd_o    = 1'b1;
                    tag_way_o    = victim_way_i;
                    tag_valid_o  = 1'b1;
                    state_d      = LOOKUP;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/dcache_mem_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_config.svh"

module dcache_mem_port (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_start_i,
    input  logic                      fill_start_i,
    input  dcache_pkg::dcache_addr_t  wb_addr_i,
    input  dcache_pkg::dcache_addr_t  fill_addr_i,
    input  logic [`DCACHE_WORD_W-1:0] wb_data_i,
    output dcache_pkg::mem_req_t      mem_req_o,
    input  dcache_pkg::mem_rsp_t      mem_rsp_i,
    output logic                      mem_done_o,
    output logic [`DCACHE_WORD_W-1:0] fill_data_o
);

    logic                      valid_q;
    logic                      done_q;
    logic                      write_q;
    logic [`DCACHE_ADDR_W-1:0] addr_q;
    logic [`DCACHE_WORD_W-1:0] wdata_q;
    logic                      accept;

    assign accept = valid_q && mem_rsp_i.ack;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            if (wb_start_i || fill_start_i) begin
                valid_q <= 1'b1;
            end else if (accept) begin
                valid_q <= 1'b0;
            end
            done_q <= accept;
        end
    end

    // fields stay put until ack, offset dropped
    always_ff @(posedge clk) begin
        if (wb_start_i) begin
            write_q <= 1'b1;
            addr_q  <= {wb_addr_i.tag, wb_addr_i.index, {`DCACHE_OFFSET_W{1'b0}}};
            wdata_q <= wb_data_i;
        end else if (fill_start_i) begin
            write_q <= 1'b0;
            addr_q  <= {fill_addr_i.tag, fill_addr_i.index, {`DCACHE_OFFSET_W{1'b0}}};
        end
        if (accept) begin
            fill_data_o <= mem_rsp_i.rdata;
        end
    end

    assign mem_done_o = done_q;
    assign mem_req_o  = '{valid: valid_q, write: write_q, addr: addr_q, wdata: wdata_q};

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid_i,
    input  dcache_pkg::core_req_t core_req_i,
    output dcache_pkg::core_rsp_t core_rsp_o,
    output dcache_pkg::mem_req_t  mem_req_o,
    input  dcache_pkg::mem_rsp_t  mem_rsp_i
);
    import dcache_pkg::*;

    core_req_t                 req;
    logic                      req_pending;
    logic                      finish;
    logic [`DCACHE_WORD_W-1:0] sel_word;
    logic                      hit;
    way_t                      hit_way;
    way_t                      victim_way;
    logic                      victim_dirty;
    dcache_addr_t              victim_addr;
    logic                      tag_upd;
    way_t                      tag_way;
    logic                      tag_valid;
    logic                      tag_dirty;
    logic                      tag_touch;
    logic                      data_we;
    way_t                      data_way;
    logic [`DCACHE_WORD_W-1:0] data_wdata;
    logic [`DCACHE_MASK_W-1:0] data_mask;
    logic [`DCACHE_WORD_W-1:0] rdata0;
    logic [`DCACHE_WORD_W-1:0] rdata1;
    logic                      wb_start;
    logic                      fill_start;
    logic                      mem_done;
    logic [`DCACHE_WORD_W-1:0] fill_data;

    dcache_core_port u_core_port (
        .clk(clk), .rst(rst), .req_valid_i(req_valid_i), .core_req_i(core_req_i),
        .finish_i(finish), .rdata_i(sel_word), .core_rsp_o(core_rsp_o),
        .req_o(req), .req_pending_o(req_pending)
    );

    dcache_tag_store u_tag_store (
        .clk(clk), .rst(rst), .addr_i(req.addr), .upd_i(tag_upd), .upd_way_i(tag_way),
        .upd_valid_i(tag_valid), .upd_dirty_i(tag_dirty), .touch_i(tag_touch),
        .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
        .victim_dirty_o(victim_dirty), .victim_addr_o(victim_addr)
    );

    dcache_data_store u_data_store (
        .clk(clk), .index_i(req.addr.index), .we_i(data_we), .way_i(data_way),
        .wdata_i(data_wdata), .mask_i(data_mask), .rdata0_o(rdata0), .rdata1_o(rdata1)
    );

    // sel_word also carries the victim word into the writeback
    dcache_ctrl u_ctrl (
        .clk(clk), .rst(rst), .req_i(req), .req_pending_i(req_pending), .hit_i(hit),
        .hit_way_i(hit_way), .victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
        .rdata0_i(rdata0), .rdata1_i(rdata1), .mem_done_i(mem_done),
        .fill_data_i(fill_data), .tag_upd_o(tag_upd), .tag_way_o(tag_way),
        .tag_valid_o(tag_valid), .tag_dirty_o(tag_dirty), .tag_touch_o(tag_touch),
        .data_we_o(data_we), .data_way_o(data_way), .data_wdata_o(data_wdata),
        .data_mask_o(data_mask), .wb_start_o(wb_start), .fill_start_o(fill_start),
        .finish_o(finish), .rdata_o(sel_word)
    );

    dcache_mem_port u_mem_port (
        .clk(clk), .rst(rst), .wb_start_i(wb_start), .fill_start_i(fill_start),
        .wb_addr_i(victim_addr), .fill_addr_i(req.addr), .wb_data_i(sel_word),
        .mem_req_o(mem_req_o), .mem_rsp_i(mem_rsp_i), .mem_done_o(mem_done),
        .fill_data_o(fill_data)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int RESET_CYCLES = 16;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

    // active low, released on a rising edge
    initial begin
        rst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* verification/dcache_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  req_valid_i,
    input dcache_pkg::core_rsp_t core_rsp_i,
    input dcache_pkg::mem_req_t  mem_req_i,
    input dcache_pkg::mem_rsp_t  mem_rsp_i
);

    // read by the testbench at the end of the run
    int fail_cnt = 0;

    // request fields frozen while memory has not acked
    hold_until_ack: assert property (@(posedge clk) disable iff (!rst)
        mem_req_i.valid && !mem_rsp_i.ack |=> mem_req_i.valid && $stable(mem_req_i))
    else begin
        $error("memory request dropped or changed before ack");
        fail_cnt++;
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        core_rsp_i.done |=> !core_rsp_i.done)
    else begin
        $error("done held high for more than one cycle");
        fail_cnt++;
    end

    // memory traffic only on behalf of a held core request
    no_mem_when_idle: assert property (@(posedge clk) disable iff (!rst)
        !req_valid_i |-> !mem_req_i.valid)
    else begin
        $error("memory request active without a core request");
        fail_cnt++;
    end

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_config.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int ACCESS_TIMEOUT  = 200;
    localparam int RESET_TIMEOUT   = 100;
    localparam int RANDOM_ACCESSES = 300;
    localparam int LONG_ACCESSES   = 40;

    logic      clk;
    logic      rst;
    logic      req_valid;
    core_req_t core_req;
    core_rsp_t core_rsp;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp = '0;

    integer   seed;
    int       errors;
    int       timeouts;
    int       accesses;
    bit       hung;
    bit       long_delay;
    int       mem_req_count;
    int       ack_delay_tab [256];
    int       delay_idx;
    int       ack_wait;
    bit       resp_busy;
    mem_req_t held_req;

    // architectural view, backing memory, and words whose newest value is dirty in the cache
    logic [`DCACHE_WORD_W-1:0] model     [logic [`DCACHE_ADDR_W-1:0]];
    logic [`DCACHE_WORD_W-1:0] backing   [logic [`DCACHE_ADDR_W-1:0]];
    bit                        dirty_set [logic [`DCACHE_ADDR_W-1:0]];
    logic [`DCACHE_ADDR_W-1:0] wb_log [$];

    // four tags on four sets, so ways get fought over
    logic [`DCACHE_TAG_W-1:0]   tag_pool [4] = '{23'h000011, 23'h2a5c3e, 23'h13579b, 23'h7fffff};
    logic [`DCACHE_INDEX_W-1:0] idx_pool [4] = '{6'd0, 6'd17, 6'd42, 6'd63};

    tb_clock_gen clock_gen (
        .clk_o(clk),
        .rst_o(rst)
    );

    dcache_top dut0 (
        .clk(clk), .rst(rst), .req_valid_i(req_valid), .core_req_i(core_req),
        .core_rsp_o(core_rsp), .mem_req_o(mem_req), .mem_rsp_i(mem_rsp)
    );

    bind dcache_top dcache_properties u_props (
        .clk(clk), .rst(rst), .req_valid_i(req_valid_i), .core_rsp_i(core_rsp_o),
        .mem_req_i(mem_req_o), .mem_rsp_i(mem_rsp_i)
    );

    // initial memory content, every address bit matters
    function automatic logic [63:0] fill_word(input logic [31:0] waddr);
        return {waddr ^ 32'hc3a5_9617, {waddr[15:0], waddr[31:16]} + 32'h0101_0101};
    endfunction

    function automatic logic [63:0] model_word(input logic [31:0] waddr);
        if (model.exists(waddr)) begin
            return model[waddr];
        end
        return fill_word(waddr);
    endfunction

    function automatic logic [63:0] backing_word(input logic [31:0] waddr);
        if (backing.exists(waddr)) begin
            return backing[waddr];
        end
        return fill_word(waddr);
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0]  mask);
        logic [63:0] result;
        result = old_word;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("** Error at %0t: %s is %h, expected %h", $time, sig, got, exp);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // finish the held memory transaction against the backing array
    task automatic serve_request();
        if (held_req.write) begin
            assert (held_req.wdata == model_word(held_req.addr))
                else report_mismatch("mem_req_o.wdata", held_req.wdata, model_word(held_req.addr));
            assert (dirty_set.exists(held_req.addr))
                else report_problem($sformatf("clean line %h was written back", held_req.addr));
            backing[held_req.addr] = held_req.wdata;
            dirty_set.delete(held_req.addr);
            wb_log.push_back(held_req.addr);
            mem_rsp <= '{ack: 1'b1, rdata: '0};
        end else begin
            assert (!dirty_set.exists(held_req.addr))
                else report_problem($sformatf("line %h refilled, its dirty data was lost",
                                              held_req.addr));
            mem_rsp <= '{ack: 1'b1, rdata: backing_word(held_req.addr)};
        end
    endtask

    // memory responder, ack after 1 to 5 cycles, 20 more in long mode
    always @(posedge clk) begin
        if (!rst) begin
            mem_rsp   <= '0;
            resp_busy = 1'b0;
        end else if (mem_rsp.ack) begin
            mem_rsp <= '0;
        end else if (resp_busy) begin
            assert (mem_req == held_req)
                else report_problem("memory request changed while waiting for ack");
            if (ack_wait > 1) begin
                ack_wait--;
            end else begin
                resp_busy = 1'b0;
                serve_request();
            end
        end else if (mem_req.valid) begin
            assert (mem_req.addr[2:0] == 3'b000)
                else report_problem($sformatf("memory address %h not word aligned", mem_req.addr));
            held_req  = mem_req;
            resp_busy = 1'b1;
            ack_wait  = ack_delay_tab[delay_idx] + (long_delay ? 20 : 0);
            delay_idx = (delay_idx + 1) % 256;
            mem_req_count++;
        end
    end

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            assert (!core_rsp.done) else report_problem("done pulsed with no request");
            assert (!mem_req.valid) else report_problem("memory request with no core request");
        end
    endtask

    // one core request, held until done
    task automatic core_access(input logic wr, input logic [31:0] addr,
                               input logic [63:0] wdata, input logic [7:0] mask,
                               input bit expect_hit);
        logic [31:0] waddr;
        int          cycles;
        int          mem_before;
        bit          got_done;
        if (hung) begin
            return;
        end
        waddr      = {addr[31:3], 3'b000};
        mem_before = mem_req_count;
        cycles     = 0;
        got_done   = 1'b0;
        @(posedge clk);
        req_valid <= 1'b1;
        core_req  <= '{write: wr, addr: addr, wdata: wdata, mask: mask};
        while (!got_done && cycles < ACCESS_TIMEOUT) begin
            @(posedge clk);
            if (core_rsp.done) begin
                got_done = 1'b1;
            end else begin
                cycles++;
            end
        end
        req_valid <= 1'b0;
        accesses++;
        if (!got_done) begin
            timeouts++;
            hung = 1'b1;
            $display("timeout at %0t: no done within %0d cycles for access to %h",
                     $time, ACCESS_TIMEOUT, addr);
            return;
        end
        if (wr) begin
            model[waddr]     = merge_bytes(model_word(waddr), wdata, mask);
            dirty_set[waddr] = 1'b1;
        end else begin
            assert (core_rsp.rdata == model_word(waddr))
                else report_mismatch("core_rsp_o.rdata", core_rsp.rdata, model_word(waddr));
        end
        if (expect_hit) begin
            assert (cycles == 3)
                else report_problem($sformatf("hit on %h took %0d cycles, expected 3", addr, cycles));
            assert (mem_req_count == mem_before)
                else report_problem($sformatf("hit on %h made a memory request", addr));
        end
    endtask

    task automatic random_access();
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [63:0] wdata;
        rnd          = $random(seed);
        wdata[63:32] = $random(seed);
        wdata[31:0]  = $random(seed);
        addr         = {tag_pool[rnd[1:0]], idx_pool[rnd[3:2]], rnd[6:4]};
        core_access(rnd[7], addr, wdata, rnd[15:8], 1'b0);
        // straight repeat of the same word has to hit
        if (rnd[17:16] == 2'b00) begin
            core_access(rnd[18], addr, ~wdata, rnd[26:19], 1'b1);
        end
    endtask

    // A then B, touch A, then C evicts B
    task automatic lru_check(input int i, input bit b_write, input bit c_write);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        bit          b_dirty;
        a = {tag_pool[0], idx_pool[i], 3'b000};
        b = {tag_pool[1], idx_pool[i], 3'b000};
        c = {tag_pool[2], idx_pool[i], 3'b000};
        core_access(~b_write, a, 64'h0123_4567_89ab_cdef, 8'h0f, 1'b0);
        core_access(b_write, b, 64'hfeed_0000_beef_1111, 8'hff, 1'b0);
        core_access(1'b0, a, '0, '0, 1'b1);
        b_dirty = dirty_set.exists(b);
        wb_log.delete();
        core_access(c_write, c, 64'h5555_aaaa_3333_cccc, 8'h3c, 1'b0);
        if (!hung) begin
            if (b_dirty) begin
                assert (wb_log.size() == 1 && wb_log[0] == b)
                    else report_problem($sformatf("miss on %h did not write back only %h", c, b));
            end else begin
                assert (wb_log.size() == 0)
                    else report_problem($sformatf("miss on %h wrote back a line", c));
            end
        end
        core_access(1'b0, a, '0, '0, 1'b1);
    endtask

    initial begin
        int n;
        req_valid = 1'b0;
        core_req  = '0;
        seed      = 32'h26cddbb2;
        for (n = 0; n < 256; n++) begin
            ack_delay_tab[n] = 1 + ($unsigned($random(seed)) % 5);
        end
        n = 0;
        while (!rst && n < RESET_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!rst) begin
            hung = 1'b1;
            timeouts++;
            $display("timeout: reset was never released");
        end else begin
            idle_check(20);
        end
        lru_check(0, 1'b1, 1'b0);
        lru_check(1, 1'b0, 1'b1);
        for (n = 0; n < RANDOM_ACCESSES && !hung; n++) begin
            random_access();
        end
        long_delay = 1'b1;
        for (n = 0; n < LONG_ACCESSES && !hung; n++) begin
            random_access();
        end
        long_delay = 1'b0;
        repeat (5) @(posedge clk);
        $display("accesses %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 accesses, errors, timeouts, dut0.u_props.fail_cnt);
        if (errors == 0 && timeouts == 0 && dut0.u_props.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_core_port.sv
hdl/dcache_tag_store.sv
hdl/dcache_data_store.sv
hdl/dcache_ctrl.sv
hdl/dcache_mem_port.sv
hdl/dcache_top.sv
verification/tb_clock_gen.sv
verification/dcache_properties.sv
verification/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module dcache_tb -f flist.f -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running after an assertion error so the testbench can report it
./obj_dir/dcache_sim +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
